//--- classDecide.sv
`timescale 1ns/1ps

module classDecide
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic actValid0,
	input logic [actWidth-1:0] act0,
	input logic actValid1,
	input logic [actWidth-1:0] act1,
	output logic resultValid,
	output logic resultClass,
	output logic [actWidth-1:0] resultScore
);

	logic bothValid;
	logic act1Wins;
	logic [actWidth-1:0] winScore;

	assign bothValid = actValid0 && actValid1;

	// ties go to class 0
	assign act1Wins = act1 > act0;
	assign winScore = act1Wins ? act1 : act0;

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= bothValid;
	end

	always_ff @(posedge clk)
	begin
		if (bothValid)
		begin
			resultClass <= act1Wins;
			resultScore <= winScore;
		end
	end

	// both neurons see the same strobes and count the same frame length
	neuronsLockstep: assert property (
		@(posedge clk) disable iff (reset)
		actValid0 == actValid1
	);

endmodule

//--- classifierCases.txt
# in0 .. in14 as signed hex bytes in frame order, then act0 act1 class score in decimal
# act is relu of (sum + bias + 32) >> 6, clamped at 127; ties give class 0
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 4 1 4
00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 54 0 0 54
00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 44 66 1 66
00 00 00 7f 7f 00 00 00 00 7f 00 00 00 00 00 127 0 0 127
00 00 00 7f 00 00 00 7f 00 00 00 00 7f 00 00 65 127 1 127
00 00 00 7f 7f 00 00 7f 00 00 00 00 7f 00 00 127 127 0 127
00 80 00 00 00 00 00 00 00 00 00 00 00 00 00 34 0 0 34
00 00 00 00 00 00 00 00 00 80 00 00 00 00 00 0 66 1 66
20 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 3 1 3
0b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 3 1 3
0a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 4 1 4
00 00 00 00 12 00 00 00 00 00 00 00 00 00 00 1 0 0 1
00 00 00 00 11 00 00 00 00 00 00 00 00 00 00 0 0 0 0
7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 0 4 1 4
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 28 46 1 46
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 0 0 0 0
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 0 4 1 4
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 0 9 1 9
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 10 25 1 25
00 00 40 00 00 00 00 00 00 00 40 00 00 00 00 28 0 0 28
00 00 00 00 00 7f 00 00 00 00 00 00 00 80 00 8 32 1 32
00 00 00 00 00 00 80 00 80 00 00 00 00 00 00 98 6 0 98
00 00 00 00 00 00 00 00 00 00 00 80 00 00 7f 60 32 0 60
00 00 00 2d 00 00 00 00 00 10 00 00 00 00 00 18 18 0 18
00 00 00 2e 00 00 00 00 00 10 00 00 00 00 00 18 19 1 19
00 00 00 2d 00 00 00 00 00 11 00 00 00 00 00 19 18 0 19
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 0 4 1 4
40 c0 40 40 40 c0 c0 40 c0 40 40 c0 40 c0 40 127 0 0 127
e0 20 e0 20 e0 20 e0 20 20 e0 e0 e0 20 20 e0 0 123 1 123

//--- classifierTop.sv
`timescale 1ns/1ps

module classifierTop
	import nnPkg::*;
#(
	parameter int numInputs = defNumInputs,
	// listed from the last element down to element 0
	parameter logic [numInputs*weightWidth-1:0] weights0 = {
		8'sd3, -8'sd12, 8'sd6, -8'sd31, 8'sd21,
		8'sd31, -8'sd22, 8'sd5, -8'sd31, -8'sd4,
		8'sd31, 8'sd26, 8'sd15, -8'sd21, 8'sd1
	},
	parameter logic signed [biasWidth-1:0] bias0 = -16'sd512,
	parameter logic [numInputs*weightWidth-1:0] weights1 = {
		-8'sd1, 8'sd8, 8'sd21, -8'sd15, -8'sd26,
		-8'sd31, 8'sd4, 8'sd31, -8'sd5, 8'sd22,
		-8'sd21, 8'sd31, -8'sd6, 8'sd12, -8'sd3
	},
	parameter logic signed [biasWidth-1:0] bias1 = 16'sd256
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic signed [actWidth-1:0] inData,
	output logic resultValid,
	output logic resultClass,
	output logic [actWidth-1:0] resultScore
);

	logic actValid0;
	logic [actWidth-1:0] act0;
	logic actValid1;
	logic [actWidth-1:0] act1;

	// both neurons share the input stream
	macNeuron #(
		.numInputs(numInputs),
		.weights(weights0),
		.bias(bias0)
	) neuron0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.actValid(actValid0),
		.act(act0)
	);

	macNeuron #(
		.numInputs(numInputs),
		.weights(weights1),
		.bias(bias1)
	) neuron1 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.actValid(actValid1),
		.act(act1)
	);

	classDecide decide (
		.clk(clk),
		.reset(reset),
		.actValid0(actValid0),
		.act0(act0),
		.actValid1(actValid1),
		.act1(act1),
		.resultValid(resultValid),
		.resultClass(resultClass),
		.resultScore(resultScore)
	);

endmodule

//--- macNeuron.sv
`timescale 1ns/1ps

module macNeuron
	import nnPkg::*;
#(
	parameter int numInputs = defNumInputs,
	// element k uses the byte at k*weightWidth
	parameter logic [numInputs*weightWidth-1:0] weights = '0,
	parameter logic signed [biasWidth-1:0] bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic signed [actWidth-1:0] inData,
	output logic actValid,
	output logic [actWidth-1:0] act
);

	localparam int cntWidth = (numInputs > 1) ? $clog2(numInputs) : 1;
	localparam logic [cntWidth-1:0] lastIdx = cntWidth'(numInputs - 1);
	localparam int prodWidth = actWidth + weightWidth;
	localparam logic signed [accWidth-1:0] biasExt = accWidth'(bias);
	localparam logic signed [accWidth-1:0] roundHalf = accWidth'(2 ** (fracBits - 1));

	neuronState state;
	neuronState stateNext;

	logic dValid;
	logic signed [actWidth-1:0] dData;
	logic [cntWidth-1:0] cnt;
	logic lastElem;

	logic signed [weightWidth-1:0] weightSel;
	logic signed [prodWidth-1:0] product;
	logic signed [accWidth-1:0] productExt;
	logic signed [accWidth-1:0] acc;
	logic signed [accWidth-1:0] accNext;
	logic signed [accWidth-1:0] sumReg;

	logic signed [accWidth-1:0] biased;
	logic signed [accWidth-1:0] rounded;
	logic signed [accWidth-fracBits-1:0] scaled;
	logic [actWidth-1:0] actNext;

	// input stage, the multiply works from here
	always_ff @(posedge clk)
	begin
		if (reset)
			dValid <= 1'b0;
		else
			dValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			dData <= inData;
	end

	// element counter picks the weight
	assign lastElem = dValid && (cnt == lastIdx);

	always_ff @(posedge clk)
	begin
		if (reset)
			cnt <= '0;
		else if (dValid)
		begin
			if (lastElem)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	assign weightSel = weights[cnt*weightWidth +: weightWidth];
	assign product = dData * weightSel;	// signed 8x8
	assign productExt = {{(accWidth - prodWidth){product[prodWidth-1]}}, product};
	assign accNext = acc + productExt;

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (lastElem)
			acc <= '0;	// free for the next frame at once
		else if (dValid)
			acc <= accNext;
	end

	// final sum of the frame, held while the next one accumulates
	always_ff @(posedge clk)
	begin
		if (lastElem)
			sumReg <= accNext;
	end

	always_comb
	begin
		stateNext = state;
		case (state)
			stIdle, stActivate:
			begin
				// a new frame can start right behind the last one
				if (lastElem)
					stateNext = stActivate;
				else if (dValid)
					stateNext = stAccum;
				else
					stateNext = stIdle;
			end
			stAccum:
			begin
				if (lastElem)
					stateNext = stActivate;
			end
			default:
				stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= stIdle;
		else
			state <= stateNext;
	end

	// bias, round half up, drop fraction
	assign biased = sumReg + biasExt;
	assign rounded = biased + roundHalf;
	assign scaled = rounded[accWidth-1:fracBits];

	always_comb
	begin
		if (biased[accWidth-1])
			actNext = '0;	// relu
		else if (scaled > actMax)
			actNext = actWidth'(actMax);
		else
			actNext = scaled[actWidth-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			actValid <= 1'b0;
		else
			actValid <= (state == stActivate);
	end

	always_ff @(posedge clk)
	begin
		if (state == stActivate)
			act <= actNext;
	end

	// counter wraps before it can index past the weight vector
	cntInRange: assert property (
		@(posedge clk) disable iff (reset)
		int'(cnt) < numInputs
	);

	actValidPulse: assert property (
		@(posedge clk) disable iff (reset)
		actValid |=> !actValid
	);

endmodule

//--- nnPkg.sv
package nnPkg;

	// data widths
	localparam int actWidth = 8;	// activations, in and out
	localparam int weightWidth = 8;
	localparam int biasWidth = 16;

	// 15 products of 16 bits plus the bias cannot overflow this
	localparam int accWidth = 23;

	// fixed point at the activation
	localparam int fracBits = 6;	// bits dropped after rounding
	localparam int actMax = 127;	// saturation ceiling

	// elements per frame unless the top level says otherwise
	localparam int defNumInputs = 15;

	typedef enum logic [1:0]
	{
		stIdle,	// no frame in progress
		stAccum,	// between first and last element
		stActivate	// bias, rounding, relu and clamp
	} neuronState;

endpackage

//--- runSim.sh
#!/bin/sh
# compile the classifier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbClassifier -f src.f -o simClassifier

output=$(./obj_dir/simClassifier)
echo "$output"

if echo "$output" | grep -q "Test passed"
then
	exit 0
fi
exit 1

//--- src.f
nnPkg.sv
macNeuron.sv
classDecide.sv
classifierTop.sv
tbClassifier.sv

//--- tbClassifier.sv
`timescale 1ns/1ps

module tbClassifier;

	localparam int numInputs = 15;
	localparam int maxCases = 64;

	logic clk;
	logic reset;
	logic inValid;
	logic signed [7:0] inData;
	logic resultValid;
	logic resultClass;
	logic [7:0] resultScore;

	// cases as read from the data file
	logic [7:0] caseIn [maxCases][numInputs];
	logic [7:0] expAct0 [maxCases];
	logic [7:0] expAct1 [maxCases];
	logic expClass [maxCases];
	logic [7:0] expScore [maxCases];
	int numCases;
	int totalFrames;

	int pendingQ [$];	// case index of every frame in flight
	int frameNum;
	int passCount;
	int failCount;
	int cycles = 0;
	int cycleLimit = 1000000;	// trimmed once the cases are known
	integer seed;

	classifierTop dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.resultValid(resultValid),
		.resultClass(resultClass),
		.resultScore(resultScore)
	);

	always #20 clk = ~clk;

	task automatic readCases();
		integer fd;
		integer n;
		int k;
		logic [8*256-1:0] line;
		int b [numInputs];
		int a0;
		int a1;
		int cls;
		int score;
		numCases = 0;
		fd = $fopen("classifierCases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open classifierCases.txt");
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %d %d",
				b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7],
				b[8], b[9], b[10], b[11], b[12], b[13], b[14],
				a0, a1, cls, score);
			// comment and blank lines do not give all 19 fields
			if (n == 19 && numCases < maxCases)
			begin
				for (k = 0; k < numInputs; k++)
					caseIn[numCases][k] = b[k][7:0];
				expAct0[numCases] = a0[7:0];
				expAct1[numCases] = a1[7:0];
				expClass[numCases] = cls[0];
				expScore[numCases] = score[7:0];
				numCases++;
			end
		end
		$fclose(fd);
		$display("%0d cases read", numCases);
	endtask

	// one frame of strobes, optionally with idle cycles before each element
	task automatic sendFrame(input int idx, input bit randomGaps);
		int k;
		int gap;
		pendingQ.push_back(idx);
		for (k = 0; k < numInputs; k++)
		begin
			gap = 0;
			if (randomGaps)
				gap = {$random(seed)} % 3;
			repeat (gap)
			begin
				@(posedge clk);
				#1 inValid = 1'b0;
			end
			@(posedge clk);
			#1;
			inValid = 1'b1;
			inData = caseIn[idx][k];
		end
	endtask

	task automatic checkResult();
		int idx;
		int errs;
		errs = 0;
		if (pendingQ.size() == 0)
		begin
			$display("resultValid at %0t ns with no frame outstanding", $time);
			failCount++;
			return;
		end
		idx = pendingQ.pop_front();
		// act0 and act1 stay put until the next frame reaches stActivate
		if (dut.act0 != expAct0[idx])
		begin
			$display("ERROR at %0t ns: act0 expected %0d got %0d",
				$time, expAct0[idx], dut.act0);
			errs++;
		end
		if (dut.act1 != expAct1[idx])
		begin
			$display("ERROR at %0t ns: act1 expected %0d got %0d",
				$time, expAct1[idx], dut.act1);
			errs++;
		end
		if (resultClass != expClass[idx])
		begin
			$display("ERROR at %0t ns: resultClass expected %0d got %0d",
				$time, expClass[idx], resultClass);
			errs++;
		end
		if (resultScore != expScore[idx])
		begin
			$display("ERROR at %0t ns: resultScore expected %0d got %0d",
				$time, expScore[idx], resultScore);
			errs++;
		end
		if (errs == 0)
		begin
			passCount++;
			$display("frame %0d case %0d ok: act0 %0d act1 %0d class %0d score %0d",
				frameNum, idx, dut.act0, dut.act1, resultClass, resultScore);
		end
		else
		begin
			failCount++;
			$display("frame %0d case %0d: %0d mismatches", frameNum, idx, errs);
		end
		frameNum++;
	endtask

	// outputs settle after the rising edge
	always @(negedge clk)
	begin
		if (!reset && resultValid)
			checkResult();
	end

	initial
	begin
		int i;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		seed = 32'hadca;
		frameNum = 0;
		passCount = 0;
		failCount = 0;
		readCases();
		totalFrames = 2 * numCases;
		cycleLimit = totalFrames * (numInputs * 3 + 10) + 100;

		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		for (i = 0; i < numCases; i++)
			sendFrame(i, 1'b0);	// back to back, no idle cycles
		for (i = 0; i < numCases; i++)
			sendFrame(i, 1'b1);
		@(posedge clk);
		#1 inValid = 1'b0;

		while (frameNum < totalFrames)
			@(posedge clk);
		repeat (10) @(posedge clk);	// catch any stray resultValid

		$display("%0d results checked, %0d passed, %0d failed",
			frameNum, passCount, failCount);
		if (numCases > 0 && failCount == 0 && passCount == totalFrames)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d of %0d results seen",
			cycles, frameNum, totalFrames);
		$display("Test failed");
		$finish;
	end

endmodule
